/* Bender.yml */
package:
  name: cache_ctrl

sources:
  - verilog/cache_ctrl_pkg.sv
  - verilog/csr_decode.sv
  - verilog/perf_counters.sv
  - verilog/csr_response.sv
  - verilog/cache_ctrl.sv
  - target: test
    files:
      - tests/cache_ctrl_checker.sv
      - tests/cache_ctrl_assert.sv
      - tests/tb_cache_ctrl.sv

/* list.f */
verilog/cache_ctrl_pkg.sv
verilog/csr_decode.sv
verilog/perf_counters.sv
verilog/csr_response.sv
verilog/cache_ctrl.sv
tests/cache_ctrl_checker.sv
tests/cache_ctrl_assert.sv
tests/tb_cache_ctrl.sv

/* tests/cache_ctrl_assert.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshake and invalidate pulse assertions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module cache_ctrl_assert #(
   parameter int DATA_W = 32
) (
   input logic                clk_i,
   input logic                arst_i,
   input logic                valid_i,
   input logic [DATA_W/8-1:0] wstrb_i,
   input logic                ready_o,
   input logic                invalidate_o
);

   a_ready_follows : assert property (@(posedge clk_i) disable iff (arst_i)
      ready_o == $past(valid_i))
      else $error("ready_o does not follow valid_i by one cycle");

   a_inval_single : assert property (@(posedge clk_i) disable iff (arst_i)
      invalidate_o |=> !invalidate_o)
      else $error("invalidate_o high for two cycles");

   // pulse only after a write request
   a_inval_after_wr : assert property (@(posedge clk_i) disable iff (arst_i)
      invalidate_o |-> $past(valid_i && wstrb_i != '0))
      else $error("invalidate_o without a preceding write");

endmodule

bind cache_ctrl cache_ctrl_assert #(.DATA_W(DATA_W)) u_assert (
   .clk_i        (clk_i),
   .arst_i       (arst_i),
   .valid_i      (valid_i),
   .wstrb_i      (wstrb_i),
   .ready_o      (ready_o),
   .invalidate_o (invalidate_o)
);

`default_nettype wire

/* tests/cache_ctrl_checker.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// response checker with event counter model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module cache_ctrl_checker
   import cache_ctrl_pkg::*;
#(
   parameter int DATA_W = 32
) (
   input  logic                  clk_i,
   input  logic                  arst_i,
   input  logic                  valid_i,
   input  logic [CSR_ADDR_W-1:0] addr_i,
   input  logic [DATA_W/8-1:0]   wstrb_i,
   input  cache_evt_t            evt_i,
   input  logic                  ready_o,
   input  logic [DATA_W-1:0]     rdata_o,
   input  logic                  invalidate_o,
   input  logic                  exp_valid_i,
   input  logic [DATA_W-1:0]     exp_rdata_i,
   input  logic                  exp_inval_i,
   output int                    err_cnt_o,
   output int                    test_cnt_o
);

   logic [DATA_W-1:0] rh, rm, wh, wm;   // model counters
   logic [DATA_W-1:0] mdl_val_q;
   logic              mdl_q;            // last cycle was a counter read
   logic              req_q;

   // byte address a write acts on: aligned word plus lowest strobe lane
   function automatic logic [CSR_ADDR_W-1:0] eff_wr_addr(
      input logic [CSR_ADDR_W-1:0] addr,
      input logic [DATA_W/8-1:0]   strb);
      int lane;
      lane = 0;
      while (lane < DATA_W/8-1 && !strb[lane]) lane++;
      return (addr & ~CSR_ADDR_W'(DATA_W/8-1)) + CSR_ADDR_W'(lane);
   endfunction

   task automatic compare_sig(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp, inout bit bad);
      if (got !== exp) begin
         $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
         bad = 1'b1;
      end
   endtask

   // outputs and inputs are both settled at the falling edge
   always @(negedge clk_i) begin
      bit bad;
      bad = 1'b0;
      if (arst_i) begin
         {rh, rm, wh, wm} = '0;
         {mdl_q, req_q}   = '0;
         mdl_val_q        = '0;
         err_cnt_o        = 0;
         test_cnt_o       = 0;
      end else begin
         if (ready_o !== req_q) begin
            if (req_q) $display("no ready in the cycle after a request at %0t", $time);
            else       $display("ready came without a request at %0t", $time);
            err_cnt_o++;
         end
         if (exp_valid_i) begin   // table row
            compare_sig("rdata_o", rdata_o, exp_rdata_i, bad);
            compare_sig("invalidate_o", invalidate_o, exp_inval_i, bad);
         end else begin           // model driven
            compare_sig("rdata_o", rdata_o, mdl_q ? mdl_val_q : '0, bad);
            compare_sig("invalidate_o", invalidate_o, '0, bad);
         end
         if (exp_valid_i || mdl_q) begin
            test_cnt_o++;
            $display("test %0d %s at %0t", test_cnt_o, bad ? "failed" : "ok", $time);
         end
         if (bad) err_cnt_o++;

         // this cycle's request, seen against counters before the update
         req_q = valid_i;
         mdl_q = valid_i && (wstrb_i == '0);
         case (addr_i)
            ADDR_RW_HIT:     mdl_val_q = rh + wh;
            ADDR_RW_MISS:    mdl_val_q = rm + wm;
            ADDR_READ_HIT:   mdl_val_q = rh;
            ADDR_READ_MISS:  mdl_val_q = rm;
            ADDR_WRITE_HIT:  mdl_val_q = wh;
            ADDR_WRITE_MISS: mdl_val_q = wm;
            default:         mdl_q     = 1'b0;
         endcase
         if (valid_i && wstrb_i != '0 && eff_wr_addr(addr_i, wstrb_i) == ADDR_RST_CNTRS) begin
            {rh, rm, wh, wm} = '0;   // events of this cycle are lost
         end else begin
            rh = rh + evt_i.read_hit;
            rm = rm + evt_i.read_miss;
            wh = wh + evt_i.write_hit;
            wm = wm + evt_i.write_miss;
         end
      end
   end

endmodule

`default_nettype wire

/* tests/tb_cache_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache control testbench: clock, reset, table
// loop, random event phase, timeout and verdict
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module tb_cache_ctrl;
   import cache_ctrl_pkg::*;

   localparam int DATA_W  = 32;
   localparam int RST_CYC = 10;
   localparam int N_RAND  = 200;

   // one cycle of stimulus plus the response due in the next cycle
   typedef struct packed {
      logic                  req;
      logic [CSR_ADDR_W-1:0] addr;
      logic [DATA_W/8-1:0]   wstrb;
      cache_evt_t            evt;
      logic                  empty;
      logic                  full;
      logic [DATA_W-1:0]     rdata;
      logic                  inval;
   } row_t;

   logic clk_i, arst_i, valid_i, wtbuf_empty_i, wtbuf_full_i;
   logic [CSR_ADDR_W-1:0] addr_i;
   logic [DATA_W/8-1:0]   wstrb_i;
   cache_evt_t            evt_i;
   logic                  ready_o, invalidate_o;
   logic [DATA_W-1:0]     rdata_o;
   logic                  exp_valid, exp_inval;
   logic [DATA_W-1:0]     exp_rdata;
   int                    err_cnt, test_cnt;
   int                    cycle_cnt = 0;
   int                    cycle_limit = 0;
   int                    seed = 32'h234f;
   row_t                  rows[$];
   logic [CSR_ADDR_W-1:0] cnt_addr[6] = '{ADDR_RW_HIT, ADDR_RW_MISS, ADDR_READ_HIT,
                                          ADDR_READ_MISS, ADDR_WRITE_HIT, ADDR_WRITE_MISS};

   cache_ctrl #(.DATA_W(DATA_W), .USE_CTRL_CNT(1'b1)) u_dut (.*);

   cache_ctrl_checker #(.DATA_W(DATA_W)) u_checker (
      .clk_i, .arst_i, .valid_i, .addr_i, .wstrb_i, .evt_i,
      .ready_o, .rdata_o, .invalidate_o,
      .exp_valid_i (exp_valid),
      .exp_rdata_i (exp_rdata),
      .exp_inval_i (exp_inval),
      .err_cnt_o   (err_cnt),
      .test_cnt_o  (test_cnt)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         $display("timeout, run stopped after %0d cycles", cycle_cnt);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic add_row(input logic req, input logic [CSR_ADDR_W-1:0] addr,
                          input logic [3:0] wstrb, input logic [3:0] evt,
                          input logic empty, input logic full,
                          input logic [DATA_W-1:0] rdata, input logic inval);
      row_t r;
      r = {req, addr, wstrb, evt, empty, full, rdata, inval};
      rows.push_back(r);
   endtask

   task automatic build_table();
      // behavior 1: counters read zero after reset
      foreach (cnt_addr[k]) add_row(1, cnt_addr[k], 4'h0, 4'b0000, 1, 0, 32'h0, 0);
      // behavior 2: events {rh, rm, wh, wm}, reads miss same-cycle events
      add_row(0, 5'h00, 4'h0, 4'b1000, 1, 0, 32'h0, 0);
      add_row(0, 5'h00, 4'h0, 4'b1111, 1, 0, 32'h0, 0);
      add_row(0, 5'h00, 4'h0, 4'b0110, 1, 0, 32'h0, 0);
      add_row(1, ADDR_READ_HIT, 4'h0, 4'b1000, 1, 0, 32'h2, 0);
      add_row(1, ADDR_READ_HIT, 4'h0, 4'b0000, 1, 0, 32'h3, 0);
      add_row(1, ADDR_READ_MISS, 4'h0, 4'b0000, 1, 0, 32'h2, 0);
      add_row(1, ADDR_WRITE_HIT, 4'h0, 4'b0000, 1, 0, 32'h2, 0);
      add_row(1, ADDR_WRITE_MISS, 4'h0, 4'b0000, 1, 0, 32'h1, 0);
      add_row(1, ADDR_RW_HIT, 4'h0, 4'b0000, 1, 0, 32'h5, 0);
      add_row(1, ADDR_RW_MISS, 4'h0, 4'b0000, 1, 0, 32'h3, 0);
      // behavior 3: clear drops same-cycle events, lane 1 hits 0x19
      add_row(1, 5'h18, 4'b0001, 4'b1111, 1, 0, 32'h0, 0);
      add_row(1, ADDR_RW_HIT, 4'h0, 4'b0000, 1, 0, 32'h0, 0);
      add_row(1, ADDR_RW_MISS, 4'h0, 4'b1000, 1, 0, 32'h0, 0);
      add_row(1, 5'h18, 4'b0010, 4'b0000, 1, 0, 32'h0, 1);
      add_row(1, ADDR_READ_HIT, 4'h0, 4'b0000, 1, 0, 32'h1, 0);
      // behavior 4: invalidate write and read
      add_row(1, 5'h19, 4'b0010, 4'b0000, 1, 0, 32'h0, 1);
      add_row(1, 5'h19, 4'h0, 4'b0000, 1, 0, 32'h0, 0);
      add_row(0, 5'h00, 4'h0, 4'b0000, 1, 0, 32'h0, 0);
      // behavior 5: status, version, unmapped, back to back
      add_row(1, ADDR_WTB_EMPTY, 4'h0, 4'b0000, 1, 0, 32'h1, 0);
      add_row(1, ADDR_WTB_FULL, 4'h0, 4'b0000, 0, 1, 32'h1, 0);
      add_row(1, ADDR_WTB_EMPTY, 4'h0, 4'b0000, 0, 1, 32'h0, 0);
      add_row(1, ADDR_WTB_FULL, 4'h0, 4'b0000, 1, 0, 32'h0, 0);
      add_row(1, ADDR_VERSION, 4'h0, 4'b0000, 1, 0, 32'h1, 0);
      add_row(1, 5'h1D, 4'h0, 4'b0000, 1, 0, 32'h0, 0);
      add_row(1, 5'h01, 4'h0, 4'b0000, 1, 0, 32'h0, 0);
      add_row(1, ADDR_WRITE_HIT, 4'hF, 4'b0000, 1, 0, 32'h0, 0);
      add_row(1, ADDR_READ_HIT, 4'h0, 4'b0000, 1, 0, 32'h1, 0);
      add_row(0, 5'h00, 4'h0, 4'b0000, 1, 0, 32'h0, 0);
   endtask

   initial begin
      row_t prev;
      int   rnd;
      arst_i        = 1'b1;
      valid_i       = 1'b0;
      addr_i        = '0;
      wstrb_i       = '0;
      evt_i         = '0;
      wtbuf_empty_i = 1'b1;
      wtbuf_full_i  = 1'b0;
      exp_valid     = 1'b0;
      exp_rdata     = '0;
      exp_inval     = 1'b0;
      prev          = '0;
      build_table();
      cycle_limit = RST_CYC + rows.size() + N_RAND + 50;
      repeat (RST_CYC) @(posedge clk_i);
      arst_i <= 1'b0;

      foreach (rows[i]) begin
         @(posedge clk_i);
         {valid_i, addr_i, wstrb_i, evt_i} <= {rows[i].req, rows[i].addr,
                                               rows[i].wstrb, rows[i].evt};
         wtbuf_empty_i <= rows[i].empty;
         wtbuf_full_i  <= rows[i].full;
         exp_valid     <= (i > 0);   // previous row's response is due now
         exp_rdata     <= prev.rdata;
         exp_inval     <= prev.inval;
         prev = rows[i];
      end
      @(posedge clk_i);
      {valid_i, wstrb_i, evt_i} <= '0;
      exp_valid <= 1'b1;
      exp_rdata <= prev.rdata;
      exp_inval <= prev.inval;

      // random events, the checker keeps its own tally
      repeat (N_RAND) begin
         @(posedge clk_i);
         rnd = $random(seed);
         evt_i     <= rnd[3:0];
         exp_valid <= 1'b0;
      end
      foreach (cnt_addr[k]) begin
         @(posedge clk_i);
         valid_i <= 1'b1;
         addr_i  <= cnt_addr[k];
         evt_i   <= '0;
      end
      @(posedge clk_i);
      valid_i <= 1'b0;
      repeat (3) @(posedge clk_i);

      $display("tests %0d, errors %0d", test_cnt, err_cnt);
      if (err_cnt == 0 && test_cnt > 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/cache_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache control and status block, top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module cache_ctrl
   import cache_ctrl_pkg::*;
#(
   parameter int DATA_W       = 32,   // 32 or 64
   parameter bit USE_CTRL_CNT = 1'b1
) (
   input  logic                  clk_i,
   input  logic                  arst_i,
   input  logic                  valid_i,
   input  logic [CSR_ADDR_W-1:0] addr_i,
   input  logic [DATA_W/8-1:0]   wstrb_i,
   input  cache_evt_t            evt_i,
   input  logic                  wtbuf_empty_i,
   input  logic                  wtbuf_full_i,
   output logic                  ready_o,
   output logic [DATA_W-1:0]     rdata_o,
   output logic                  invalidate_o
);

   csr_cmd_t          cmd;
   logic [DATA_W-1:0] read_hit_cnt;
   logic [DATA_W-1:0] read_miss_cnt;
   logic [DATA_W-1:0] write_hit_cnt;
   logic [DATA_W-1:0] write_miss_cnt;

   csr_decode #(
      .DATA_W (DATA_W)
   ) u_decode (
      .valid_i (valid_i),
      .addr_i  (addr_i),
      .wstrb_i (wstrb_i),
      .cmd_o   (cmd)
   );

   perf_counters #(
      .DATA_W       (DATA_W),
      .USE_CTRL_CNT (USE_CTRL_CNT)
   ) u_counters (
      .clk_i            (clk_i),
      .arst_i           (arst_i),
      .cmd_i            (cmd),
      .evt_i            (evt_i),
      .read_hit_cnt_o   (read_hit_cnt),
      .read_miss_cnt_o  (read_miss_cnt),
      .write_hit_cnt_o  (write_hit_cnt),
      .write_miss_cnt_o (write_miss_cnt)
   );

   // counter values seen here are pre-update, so reads miss same-cycle events
   csr_response #(
      .DATA_W (DATA_W)
   ) u_response (
      .clk_i            (clk_i),
      .arst_i           (arst_i),
      .cmd_i            (cmd),
      .read_hit_cnt_i   (read_hit_cnt),
      .read_miss_cnt_i  (read_miss_cnt),
      .write_hit_cnt_i  (write_hit_cnt),
      .write_miss_cnt_i (write_miss_cnt),
      .wtbuf_empty_i    (wtbuf_empty_i),
      .wtbuf_full_i     (wtbuf_full_i),
      .ready_o          (ready_o),
      .rdata_o          (rdata_o),
      .invalidate_o     (invalidate_o)
   );

endmodule

`default_nettype wire

/* verilog/cache_ctrl_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache control register map, version constant,
// register selector and operation enums, cmd/event structs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package cache_ctrl_pkg;

   // byte address width of the register space
   localparam int CSR_ADDR_W = 5;

   // performance counters, one full word each
   localparam logic [CSR_ADDR_W-1:0] ADDR_RW_HIT     = 5'h00;
   localparam logic [CSR_ADDR_W-1:0] ADDR_RW_MISS    = 5'h04;
   localparam logic [CSR_ADDR_W-1:0] ADDR_READ_HIT   = 5'h08;
   localparam logic [CSR_ADDR_W-1:0] ADDR_READ_MISS  = 5'h0C;
   localparam logic [CSR_ADDR_W-1:0] ADDR_WRITE_HIT  = 5'h10;
   localparam logic [CSR_ADDR_W-1:0] ADDR_WRITE_MISS = 5'h14;

   // single byte commands, write only
   localparam logic [CSR_ADDR_W-1:0] ADDR_RST_CNTRS  = 5'h18;
   localparam logic [CSR_ADDR_W-1:0] ADDR_INVALIDATE = 5'h19;

   // write-through buffer status bytes
   localparam logic [CSR_ADDR_W-1:0] ADDR_WTB_EMPTY  = 5'h1A;
   localparam logic [CSR_ADDR_W-1:0] ADDR_WTB_FULL   = 5'h1B;

   localparam logic [CSR_ADDR_W-1:0] ADDR_VERSION    = 5'h1C;

   localparam logic [15:0] CSR_VERSION = 16'h0001;

   // which register a request hits
   typedef enum logic [3:0] {
      SEL_NONE,
      SEL_RW_HIT,
      SEL_RW_MISS,
      SEL_READ_HIT,
      SEL_READ_MISS,
      SEL_WRITE_HIT,
      SEL_WRITE_MISS,
      SEL_RST_CNTRS,
      SEL_INVALIDATE,
      SEL_WTB_EMPTY,
      SEL_WTB_FULL,
      SEL_VERSION
   } csr_sel_e;

   typedef enum logic {
      OP_READ,
      OP_WRITE
   } csr_op_e;

   // decoded request, valid for one cycle
   typedef struct packed {
      logic     valid;
      csr_op_e  op;
      csr_sel_e sel;
   } csr_cmd_t;

   // event strobes from the cache
   typedef struct packed {
      logic read_hit;
      logic read_miss;
      logic write_hit;
      logic write_miss;
   } cache_evt_t;

endpackage

`default_nettype wire

/* verilog/csr_decode.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request decoder: strobe lane encoder, write
// address forming and register map lookup
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module csr_decode
   import cache_ctrl_pkg::*;
#(
   parameter int DATA_W = 32
) (
   input  logic                  valid_i,
   input  logic [CSR_ADDR_W-1:0] addr_i,
   input  logic [DATA_W/8-1:0]   wstrb_i,
   output csr_cmd_t              cmd_o
);

   localparam int WSTRB_W = DATA_W/8;
   localparam int LANE_W  = $clog2(WSTRB_W);

   logic [LANE_W-1:0]     lane;       // lowest active byte lane
   logic [CSR_ADDR_W-1:0] addr_algn;
   logic [CSR_ADDR_W-1:0] wr_addr;
   csr_sel_e              rd_sel;
   csr_sel_e              wr_sel;

   // exact byte address to register selector
   function automatic csr_sel_e map_addr(input logic [CSR_ADDR_W-1:0] a);
      csr_sel_e s;
      case (a)
         ADDR_RW_HIT:     s = SEL_RW_HIT;
         ADDR_RW_MISS:    s = SEL_RW_MISS;
         ADDR_READ_HIT:   s = SEL_READ_HIT;
         ADDR_READ_MISS:  s = SEL_READ_MISS;
         ADDR_WRITE_HIT:  s = SEL_WRITE_HIT;
         ADDR_WRITE_MISS: s = SEL_WRITE_MISS;
         ADDR_RST_CNTRS:  s = SEL_RST_CNTRS;
         ADDR_INVALIDATE: s = SEL_INVALIDATE;
         ADDR_WTB_EMPTY:  s = SEL_WTB_EMPTY;
         ADDR_WTB_FULL:   s = SEL_WTB_FULL;
         ADDR_VERSION:    s = SEL_VERSION;
         default:         s = SEL_NONE;
      endcase
      return s;
   endfunction

   // priority encoder, lowest set strobe wins
   always_comb begin
      lane = '0;
      for (int i = WSTRB_W-1; i >= 0; i--) begin
         if (wstrb_i[i]) begin
            lane = LANE_W'(i);
         end
      end
   end

   assign addr_algn = {addr_i[CSR_ADDR_W-1:LANE_W], {LANE_W{1'b0}}};
   assign wr_addr   = addr_algn + CSR_ADDR_W'(lane);

   assign rd_sel = map_addr(addr_i);   // reads need an exact hit

   // only the two command bytes are writable
   always_comb begin
      wr_sel = map_addr(wr_addr);
      if (wr_sel != SEL_RST_CNTRS && wr_sel != SEL_INVALIDATE) begin
         wr_sel = SEL_NONE;
      end
   end

   always_comb begin
      cmd_o.valid = valid_i;
      cmd_o.op    = OP_READ;
      cmd_o.sel   = SEL_NONE;
      if (valid_i) begin
         if (wstrb_i == '0) begin  // no strobes means read
            cmd_o.op  = OP_READ;
            cmd_o.sel = rd_sel;
         end else begin
            cmd_o.op  = OP_WRITE;
            cmd_o.sel = wr_sel;
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/csr_response.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read data mux with totals, registered ready,
// read data and invalidate pulse
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module csr_response
   import cache_ctrl_pkg::*;
#(
   parameter int DATA_W = 32
) (
   input  logic              clk_i,
   input  logic              arst_i,
   input  csr_cmd_t          cmd_i,
   input  logic [DATA_W-1:0] read_hit_cnt_i,
   input  logic [DATA_W-1:0] read_miss_cnt_i,
   input  logic [DATA_W-1:0] write_hit_cnt_i,
   input  logic [DATA_W-1:0] write_miss_cnt_i,
   input  logic              wtbuf_empty_i,
   input  logic              wtbuf_full_i,
   output logic              ready_o,
   output logic [DATA_W-1:0] rdata_o,
   output logic              invalidate_o
);

   logic [DATA_W-1:0] hit_total;
   logic [DATA_W-1:0] miss_total;
   logic [DATA_W-1:0] rdata_d;
   logic              inval_d;

   assign hit_total  = read_hit_cnt_i + write_hit_cnt_i;
   assign miss_total = read_miss_cnt_i + write_miss_cnt_i;

   always_comb begin
      rdata_d = '0;   // zero unless a read lands on a mapped register
      if (cmd_i.valid && cmd_i.op == OP_READ) begin
         case (cmd_i.sel)
            SEL_RW_HIT:     rdata_d = hit_total;
            SEL_RW_MISS:    rdata_d = miss_total;
            SEL_READ_HIT:   rdata_d = read_hit_cnt_i;
            SEL_READ_MISS:  rdata_d = read_miss_cnt_i;
            SEL_WRITE_HIT:  rdata_d = write_hit_cnt_i;
            SEL_WRITE_MISS: rdata_d = write_miss_cnt_i;
            SEL_WTB_EMPTY:  rdata_d = {{(DATA_W-1){1'b0}}, wtbuf_empty_i};
            SEL_WTB_FULL:   rdata_d = {{(DATA_W-1){1'b0}}, wtbuf_full_i};
            SEL_VERSION:    rdata_d = {{(DATA_W-16){1'b0}}, CSR_VERSION};
            default:        rdata_d = '0;   // command bytes read as zero
         endcase
      end
   end

   assign inval_d = cmd_i.valid && (cmd_i.op == OP_WRITE) && (cmd_i.sel == SEL_INVALIDATE);

   // one stage, everything drops back to 0 without a command
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         ready_o      <= 1'b0;
         rdata_o      <= '0;
         invalidate_o <= 1'b0;
      end else begin
         ready_o      <= cmd_i.valid;   // ack one cycle after request
         rdata_o      <= rdata_d;
         invalidate_o <= inval_d;
      end
   end

endmodule

`default_nettype wire

/* verilog/perf_counters.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache hit and miss event counters
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module perf_counters
   import cache_ctrl_pkg::*;
#(
   parameter int DATA_W       = 32,
   parameter bit USE_CTRL_CNT = 1'b1
) (
   input  logic              clk_i,
   input  logic              arst_i,
   input  csr_cmd_t          cmd_i,
   input  cache_evt_t        evt_i,
   output logic [DATA_W-1:0] read_hit_cnt_o,
   output logic [DATA_W-1:0] read_miss_cnt_o,
   output logic [DATA_W-1:0] write_hit_cnt_o,
   output logic [DATA_W-1:0] write_miss_cnt_o
);

   localparam int N_CNT = 4;

   // counter slots follow the event struct bit order
   localparam int IDX_READ_HIT   = 3;
   localparam int IDX_READ_MISS  = 2;
   localparam int IDX_WRITE_HIT  = 1;
   localparam int IDX_WRITE_MISS = 0;

   generate
      if (USE_CTRL_CNT) begin : g_cnt

         logic [N_CNT-1:0]             evt_vec;
         logic [N_CNT-1:0][DATA_W-1:0] cnt_q;
         logic                         clr;

         assign evt_vec = evt_i;

         // reset-counters write, acts at the end of this cycle
         assign clr = cmd_i.valid
                      && (cmd_i.op == OP_WRITE)
                      && (cmd_i.sel == SEL_RST_CNTRS);

         always_ff @(posedge clk_i or posedge arst_i) begin
            if (arst_i) begin
               cnt_q <= '0;
            end else if (clr) begin
               cnt_q <= '0;   // same-cycle events are dropped
            end else begin
               // every strobe counts, several per cycle allowed
               for (int i = 0; i < N_CNT; i++) begin
                  if (evt_vec[i]) begin
                     cnt_q[i] <= cnt_q[i] + 1'b1;   // wraps
                  end
               end
            end
         end

         assign read_hit_cnt_o   = cnt_q[IDX_READ_HIT];
         assign read_miss_cnt_o  = cnt_q[IDX_READ_MISS];
         assign write_hit_cnt_o  = cnt_q[IDX_WRITE_HIT];
         assign write_miss_cnt_o = cnt_q[IDX_WRITE_MISS];

      end else begin : g_no_cnt

         // counters left out, reads give zero
         assign read_hit_cnt_o   = '0;
         assign read_miss_cnt_o  = '0;
         assign write_hit_cnt_o  = '0;
         assign write_miss_cnt_o = '0;

      end
   endgenerate

endmodule

`default_nettype wire
